// ==== hw/cache_consts.svh ====
// cache geometry constants
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cpu address width
`define CACHE_S_ADDR 32

// byte offset within a 32-byte line
`define CACHE_S_OFFSET 5

// 8 sets
`define CACHE_S_INDEX 3

`define CACHE_S_TAG (`CACHE_S_ADDR - `CACHE_S_OFFSET - `CACHE_S_INDEX)

`define CACHE_NUM_WAYS 2
`define CACHE_NUM_SETS (1 << `CACHE_S_INDEX)

// bytes per line and width of the line byte enable
`define CACHE_S_MASK (1 << `CACHE_S_OFFSET)

// bits per line
`define CACHE_S_LINE (8 * `CACHE_S_MASK)

`endif

// ==== hw/cache_pkg.sv ====
// cache shared types
`include "cache_consts.svh"

package cache_pkg;

    typedef logic [`CACHE_S_ADDR-1:0] word_t;
    typedef logic [`CACHE_S_LINE-1:0] line_t;
    typedef logic [`CACHE_S_MASK-1:0] line_mask_t;
    typedef logic [`CACHE_S_TAG-1:0] tag_t;
    typedef logic [`CACHE_S_INDEX-1:0] index_t;
    typedef logic [3:0] byte_mask_t;       // one bit per byte of a word
    typedef logic [$clog2(`CACHE_NUM_WAYS)-1:0] way_sel_t;

    // held by the cpu until cpu_resp
    typedef struct packed {
        logic read;
        logic write;
        word_t addr;
        word_t wdata;
        byte_mask_t wmask;
    } cpu_req_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_fill,
        st_respond
    } cache_state_e;

endpackage

// ==== hw/cache_way.sv ====
// one cache way
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_way (
    input  logic                   clk,
    input  logic                   rst_n,
    input  cache_pkg::index_t      index,
    input  cache_pkg::tag_t        tag,
    input  logic                   load_tag,
    input  logic                   set_valid,
    input  logic                   dirty_load,
    input  logic                   dirty_in,
    input  cache_pkg::line_mask_t  line_we,
    input  cache_pkg::line_t       line_in,
    output logic                   way_hit,
    output cache_pkg::tag_t        way_tag,
    output logic                   way_dirty,
    output cache_pkg::line_t       way_line
);
    import cache_pkg::*;

    tag_t tags [`CACHE_NUM_SETS];
    line_t lines [`CACHE_NUM_SETS];
    logic [`CACHE_NUM_SETS-1:0] valid;
    logic [`CACHE_NUM_SETS-1:0] dirty;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid <= '0;
            dirty <= '0;
        end
        else
        begin
            if (set_valid)
                valid[index] <= 1'b1;
            if (dirty_load)
                dirty[index] <= dirty_in;
        end
    end

    // tag and data storage written byte by byte
    always_ff @(posedge clk)
    begin
        if (load_tag)
            tags[index] <= tag;
        for (int b = 0; b < `CACHE_S_MASK; b++)
        begin
            if (line_we[b])
                lines[index][8*b +: 8] <= line_in[8*b +: 8];
        end
    end

    assign way_tag   = tags[index];
    assign way_dirty = dirty[index];
    assign way_line  = lines[index];
    assign way_hit   = valid[index] && (tags[index] == tag);

    // a line only becomes valid together with its tag
    a_valid_with_tag: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(set_valid) |-> load_tag);

endmodule

// ==== hw/cache_datapath.sv ====
// cache datapath
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_datapath (
    input  logic                  clk,
    input  logic                  rst_n,
    input  cache_pkg::cpu_req_t   cpu_req,
    input  logic                  load_tag,
    input  logic                  set_valid,
    input  logic                  set_dirty,
    input  logic                  reset_dirty,
    input  logic                  set_lru,
    input  logic                  load_data,
    input  logic                  pmem_write,
    input  logic                  fill_sel,
    input  cache_pkg::line_t      pmem_rdata,
    output logic                  hit,
    output logic                  dirty,
    output cache_pkg::word_t      cpu_rdata,
    output cache_pkg::word_t      pmem_address,
    output cache_pkg::line_t      pmem_wdata
);
    import cache_pkg::*;

    localparam int WORDS = `CACHE_S_LINE / $bits(word_t);

    tag_t tag;
    index_t index;
    logic [`CACHE_S_OFFSET-3:0] word_off;
    line_mask_t word_we;
    line_t line_in;

    way_sel_t lru [`CACHE_NUM_SETS];
    way_sel_t lru_way;
    way_sel_t hit_way;

    logic [`CACHE_NUM_WAYS-1:0] way_hit;
    logic [`CACHE_NUM_WAYS-1:0] way_dirty;
    tag_t way_tag [`CACHE_NUM_WAYS];
    line_t way_line [`CACHE_NUM_WAYS];

    assign tag      = cpu_req.addr[`CACHE_S_ADDR-1 -: `CACHE_S_TAG];
    assign index    = cpu_req.addr[`CACHE_S_OFFSET +: `CACHE_S_INDEX];
    assign word_off = cpu_req.addr[`CACHE_S_OFFSET-1:2];

    // cpu word placed within the line
    assign word_we = line_mask_t'(cpu_req.wmask) << {word_off, 2'b00};
    assign line_in = fill_sel ? pmem_rdata : {WORDS{cpu_req.wdata}};

    generate
        for (genvar w = 0; w < `CACHE_NUM_WAYS; w++)
        begin : g_way
            logic is_victim;
            line_mask_t we;

            assign is_victim = (lru_way == way_sel_t'(w));
            assign we = !load_data ? '0 :
                        fill_sel   ? (is_victim ? '1 : '0) :
                                     (way_hit[w] ? word_we : '0);

            cache_way u_way (
                .clk        (clk),
                .rst_n      (rst_n),
                .index      (index),
                .tag        (tag),
                .load_tag   (load_tag && is_victim),
                .set_valid  (set_valid && is_victim),
                .dirty_load ((set_dirty && way_hit[w]) || (reset_dirty && is_victim)),
                .dirty_in   (set_dirty),
                .line_we    (we),
                .line_in    (line_in),
                .way_hit    (way_hit[w]),
                .way_tag    (way_tag[w]),
                .way_dirty  (way_dirty[w]),
                .way_line   (way_line[w])
            );
        end
    endgenerate

    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < `CACHE_NUM_WAYS; w++)
        begin
            if (way_hit[w])
                hit_way = way_sel_t'(w);
        end
    end

    // lru points at the way not just used
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int s = 0; s < `CACHE_NUM_SETS; s++)
                lru[s] <= '0;
        end
        else if (set_lru)
        begin
            lru[index] <= ~hit_way;
        end
    end

    assign lru_way = lru[index];

    assign hit        = |way_hit;
    assign dirty      = way_dirty[lru_way];    // victim
    assign pmem_wdata = way_line[lru_way];
    assign cpu_rdata  = way_line[hit_way][32*word_off +: 32];

    // write-back goes to the victim's line, fill to the request's
    assign pmem_address = pmem_write ?
        {way_tag[lru_way], index, {`CACHE_S_OFFSET{1'b0}}} :
        {tag, index, {`CACHE_S_OFFSET{1'b0}}};

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(way_hit));

endmodule

// ==== hw/cache_control.sv ====
// cache controller
`timescale 1ns/1ps

module cache_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    input  logic                 hit,
    input  logic                 dirty,
    input  logic                 pmem_resp,
    output logic                 cpu_resp,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output logic                 load_tag,
    output logic                 set_valid,
    output logic                 set_dirty,
    output logic                 reset_dirty,
    output logic                 set_lru,
    output logic                 load_data,
    output logic                 fill_sel
);
    import cache_pkg::*;

    cache_state_e state;
    cache_state_e next_state;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            state <= st_idle;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state  = state;
        cpu_resp    = 1'b0;
        pmem_read   = 1'b0;
        pmem_write  = 1'b0;
        load_tag    = 1'b0;
        set_valid   = 1'b0;
        set_dirty   = 1'b0;
        reset_dirty = 1'b0;
        set_lru     = 1'b0;
        load_data   = 1'b0;
        fill_sel    = 1'b0;

        unique case (state)
            st_idle:
            begin
                if (cpu_req.read || cpu_req.write)
                    next_state = st_compare;
            end
            st_compare:
            begin
                if (hit)
                    next_state = st_respond;
                else if (dirty)
                    next_state = st_writeback;    // victim needs saving first
                else
                    next_state = st_fill;
            end
            st_writeback:
            begin
                pmem_write = 1'b1;
                if (pmem_resp)
                    next_state = st_fill;
            end
            st_fill:
            begin
                pmem_read = 1'b1;
                if (pmem_resp)
                begin
                    load_tag    = 1'b1;
                    set_valid   = 1'b1;
                    reset_dirty = 1'b1;
                    load_data   = 1'b1;
                    fill_sel    = 1'b1;
                    next_state  = st_respond;
                end
            end
            st_respond:
            begin
                cpu_resp = 1'b1;
                set_lru  = 1'b1;
                if (cpu_req.write)
                begin
                    set_dirty = 1'b1;
                    load_data = 1'b1;    // merge cpu word
                end
                next_state = st_idle;
            end
            default: next_state = st_idle;
        endcase
    end

    a_one_pmem_op: assert property (@(posedge clk) disable iff (!rst_n)
        !(pmem_read && pmem_write));

endmodule

// ==== hw/cache.sv ====
// cache top level
`timescale 1ns/1ps

module cache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::cpu_req_t  cpu_req,
    output cache_pkg::word_t     cpu_rdata,
    output logic                 cpu_resp,
    output logic                 pmem_read,
    output logic                 pmem_write,
    output cache_pkg::word_t     pmem_address,
    output cache_pkg::line_t     pmem_wdata,
    input  cache_pkg::line_t     pmem_rdata,
    input  logic                 pmem_resp
);
    logic hit;
    logic dirty;
    logic load_tag;
    logic set_valid;
    logic set_dirty;
    logic reset_dirty;
    logic set_lru;
    logic load_data;
    logic fill_sel;

    cache_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .cpu_req     (cpu_req),
        .hit         (hit),
        .dirty       (dirty),
        .pmem_resp   (pmem_resp),
        .cpu_resp    (cpu_resp),
        .pmem_read   (pmem_read),
        .pmem_write  (pmem_write),
        .load_tag    (load_tag),
        .set_valid   (set_valid),
        .set_dirty   (set_dirty),
        .reset_dirty (reset_dirty),
        .set_lru     (set_lru),
        .load_data   (load_data),
        .fill_sel    (fill_sel)
    );

    cache_datapath u_datapath (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .load_tag     (load_tag),
        .set_valid    (set_valid),
        .set_dirty    (set_dirty),
        .reset_dirty  (reset_dirty),
        .set_lru      (set_lru),
        .load_data    (load_data),
        .pmem_write   (pmem_write),
        .fill_sel     (fill_sel),
        .pmem_rdata   (pmem_rdata),
        .hit          (hit),
        .dirty        (dirty),
        .cpu_rdata    (cpu_rdata),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata)
    );

endmodule

// ==== tb/pmem_model.sv ====
// line-wide memory model
`timescale 1ns/1ps
`include "cache_consts.svh"

module pmem_model (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              pmem_read,
    input  logic              pmem_write,
    input  cache_pkg::word_t  pmem_address,
    input  cache_pkg::line_t  pmem_wdata,
    output cache_pkg::line_t  pmem_rdata,
    output logic              pmem_resp,
    output int                write_count
);
    import cache_pkg::*;

    line_t mem [word_t];    // only lines written back so far
    logic busy;
    int delay;

    // every word depends on its full byte address
    function automatic line_t pattern_line(word_t base);
        line_t l;
        for (int i = 0; i < `CACHE_S_LINE / 32; i++)
            l[32*i +: 32] = ((base + word_t'(4 * i)) * 32'h9e37_79b1) ^ 32'h5bd1_e995;
        return l;
    endfunction

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            pmem_resp   <= 1'b0;
            pmem_rdata  <= '0;
            busy        <= 1'b0;
            delay       <= 0;
            write_count <= 0;
        end
        else if (pmem_resp)
            pmem_resp <= 1'b0;    // cache drops its request on this edge
        else if (pmem_read || pmem_write)
        begin
            if (!busy)
            begin
                busy  <= 1'b1;
                delay <= int'($urandom % 8);    // 1 to 8 more cycles
            end
            else if (delay == 0)
            begin
                busy      <= 1'b0;
                pmem_resp <= 1'b1;
                if (pmem_write)
                begin
                    mem[pmem_address] = pmem_wdata;
                    write_count <= write_count + 1;
                end
                else if (mem.exists(pmem_address))
                    pmem_rdata <= mem[pmem_address];
                else
                    pmem_rdata <= pattern_line(pmem_address);
            end
            else
                delay <= delay - 1;
        end
    end

endmodule

// ==== tb/cache_tb.sv ====
// cache testbench
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb;
    import cache_pkg::*;

    localparam int N_ENTRIES = 20;
    localparam int TIMEOUT = 16 + N_ENTRIES * 40;

    typedef struct packed {
        logic write;
        word_t addr;
        word_t wdata;
        byte_mask_t wmask;
    } stim_t;

    logic clk;
    logic rst_n;
    cpu_req_t cpu_req;
    word_t cpu_rdata;
    logic cpu_resp;
    logic pmem_read;
    logic pmem_write;
    word_t pmem_address;
    line_t pmem_wdata;
    line_t pmem_rdata;
    logic pmem_resp;
    int write_count;

    stim_t stim [N_ENTRIES];
    word_t shadow [word_t];    // written words, by word address
    tag_t m_tag [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic m_valid [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    logic m_dirty [`CACHE_NUM_SETS][`CACHE_NUM_WAYS];
    int m_lru [`CACHE_NUM_SETS];

    int errors = 0;
    int cycles = 0;
    int n_reads;
    int n_writes;
    word_t rd_addr;
    word_t wr_addr;
    line_t wr_data;
    logic wb_first;

    cache uut (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .cpu_rdata    (cpu_rdata),
        .cpu_resp     (cpu_resp),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    pmem_model mem_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_address (pmem_address),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .write_count  (write_count)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT)
        begin
            $display("timeout: no cache response within %0d cycles", TIMEOUT);
            $display("errors: %0d", errors);
            $display("sim failed");
            $finish;
        end
    end

    // memory contents before any write-back
    function automatic word_t pattern_word(word_t a);
        return (a * 32'h9e37_79b1) ^ 32'h5bd1_e995;
    endfunction

    function automatic word_t shadow_word(word_t a);
        word_t aligned;
        aligned = {a[31:2], 2'b00};
        if (shadow.exists(aligned))
            return shadow[aligned];
        return pattern_word(aligned);
    endfunction

    function automatic line_t shadow_line(word_t base);
        line_t l;
        for (int i = 0; i < `CACHE_S_LINE / 32; i++)
            l[32*i +: 32] = shadow_word(base + word_t'(4 * i));
        return l;
    endfunction

    task automatic report_mismatch(input string name, input string got, input string exp);
        errors++;
        $display("Fail at %0t: %s got %s expected %s", $time, name, got, exp);
    endtask

    // one cpu access with memory traffic logged until cpu_resp
    task automatic run_access(input stim_t s, output word_t rdata, output int lat);
        lat = 0;
        n_reads = 0;
        n_writes = 0;
        wb_first = 1'b0;
        cpu_req.read = !s.write;
        cpu_req.write = s.write;
        cpu_req.addr = s.addr;
        cpu_req.wdata = s.wdata;
        cpu_req.wmask = s.wmask;
        do
        begin
            @(negedge clk);
            lat++;
            if (pmem_resp && pmem_read)
            begin
                n_reads++;
                rd_addr = pmem_address;
            end
            if (pmem_resp && pmem_write)
            begin
                n_writes++;
                wr_addr = pmem_address;
                wr_data = pmem_wdata;
                wb_first = (n_reads == 0);
            end
        end
        while (!cpu_resp);
        rdata = cpu_rdata;
        @(negedge clk);    // request held through the response edge
        cpu_req.read = 1'b0;
        cpu_req.write = 1'b0;
    endtask

    initial
    begin
        stim_t s;
        index_t set;
        tag_t tag;
        word_t line_addr;
        word_t aligned;
        word_t merged;
        word_t exp_rdata;
        word_t exp_wb_addr;
        line_t exp_wb_data;
        word_t got;
        int hit_way;
        int exp_wb;
        int total_wb;
        int lat;
        logic was_hit;

        void'($urandom(96293));
        total_wb = 0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        rst_n = 1'b0;
        cpu_req = '0;

        // three tags fight over the two ways of set 1
        stim[0]  = '{1'b0, 32'h0000_1024, 32'h0000_0000, 4'b0000};
        stim[1]  = '{1'b0, 32'h0000_1024, 32'h0000_0000, 4'b0000};
        stim[2]  = '{1'b1, 32'h0000_1028, 32'hdead_beef, 4'b0101};
        stim[3]  = '{1'b0, 32'h0000_1028, 32'h0000_0000, 4'b0000};
        stim[4]  = '{1'b0, 32'h0000_2020, 32'h0000_0000, 4'b0000};
        stim[5]  = '{1'b0, 32'h0000_1030, 32'h0000_0000, 4'b0000};
        stim[6]  = '{1'b0, 32'h0000_3020, 32'h0000_0000, 4'b0000};
        stim[7]  = '{1'b0, 32'h0000_1024, 32'h0000_0000, 4'b0000};
        stim[8]  = '{1'b0, 32'h0000_2020, 32'h0000_0000, 4'b0000};
        stim[9]  = '{1'b0, 32'h0000_3020, 32'h0000_0000, 4'b0000};
        stim[10] = '{1'b0, 32'h0000_1028, 32'h0000_0000, 4'b0000};
        // write misses in set 2 leave both ways dirty
        stim[11] = '{1'b1, 32'h0000_0040, 32'h1234_5678, 4'b1111};
        stim[12] = '{1'b1, 32'h0000_0044, 32'ha5a5_a5a5, 4'b1000};
        stim[13] = '{1'b0, 32'h0000_0044, 32'h0000_0000, 4'b0000};
        stim[14] = '{1'b1, 32'h0001_0040, 32'h0bad_f00d, 4'b0011};
        stim[15] = '{1'b0, 32'h0002_0040, 32'h0000_0000, 4'b0000};
        stim[16] = '{1'b0, 32'h0000_0044, 32'h0000_0000, 4'b0000};
        stim[17] = '{1'b0, 32'h0000_00e0, 32'h0000_0000, 4'b0000};
        stim[18] = '{1'b1, 32'h0000_00fc, 32'hcafe_0042, 4'b1111};
        stim[19] = '{1'b0, 32'h0000_00fc, 32'h0000_0000, 4'b0000};

        for (int st = 0; st < `CACHE_NUM_SETS; st++)
        begin
            m_lru[st] = 0;
            for (int wy = 0; wy < `CACHE_NUM_WAYS; wy++)
            begin
                m_tag[st][wy] = '0;
                m_valid[st][wy] = 1'b0;
                m_dirty[st][wy] = 1'b0;
            end
        end

        repeat (16) @(negedge clk);
        if (cpu_resp !== 1'b0)
            report_mismatch("cpu_resp", $sformatf("%b", cpu_resp), "0");
        if (pmem_read !== 1'b0)
            report_mismatch("pmem_read", $sformatf("%b", pmem_read), "0");
        if (pmem_write !== 1'b0)
            report_mismatch("pmem_write", $sformatf("%b", pmem_write), "0");
        rst_n = 1'b1;

        for (int i = 0; i < N_ENTRIES; i++)
        begin
            s = stim[i];
            set = s.addr[`CACHE_S_OFFSET +: `CACHE_S_INDEX];
            tag = s.addr[31 -: `CACHE_S_TAG];
            line_addr = {s.addr[31:`CACHE_S_OFFSET], {`CACHE_S_OFFSET{1'b0}}};
            hit_way = -1;
            for (int wy = 0; wy < `CACHE_NUM_WAYS; wy++)
            begin
                if (m_valid[set][wy] && m_tag[set][wy] == tag)
                    hit_way = wy;
            end
            was_hit = (hit_way >= 0);
            exp_wb = 0;
            if (!was_hit)
            begin
                hit_way = m_lru[set];    // victim
                if (m_valid[set][hit_way] && m_dirty[set][hit_way])
                begin
                    exp_wb = 1;
                    exp_wb_addr = {m_tag[set][hit_way], set, {`CACHE_S_OFFSET{1'b0}}};
                    exp_wb_data = shadow_line(exp_wb_addr);
                end
                m_tag[set][hit_way] = tag;
                m_valid[set][hit_way] = 1'b1;
                m_dirty[set][hit_way] = 1'b0;
            end
            total_wb += exp_wb;
            exp_rdata = shadow_word(s.addr);
            if (s.write)
            begin
                aligned = {s.addr[31:2], 2'b00};
                merged = shadow_word(aligned);
                for (int b = 0; b < 4; b++)
                begin
                    if (s.wmask[b])
                        merged[8*b +: 8] = s.wdata[8*b +: 8];
                end
                shadow[aligned] = merged;
                m_dirty[set][hit_way] = 1'b1;
            end
            m_lru[set] = 1 - hit_way;

            run_access(s, got, lat);

            if (!s.write && got != exp_rdata)
                report_mismatch("cpu_rdata", $sformatf("%h", got), $sformatf("%h", exp_rdata));
            if (was_hit && lat != 2)
                report_mismatch("cpu_resp latency", $sformatf("%0d", lat), "2");
            if (n_reads != (was_hit ? 0 : 1))
                report_mismatch("pmem_read count", $sformatf("%0d", n_reads),
                                $sformatf("%0d", was_hit ? 0 : 1));
            if (!was_hit && n_reads == 1 && rd_addr != line_addr)
                report_mismatch("pmem_address", $sformatf("%h", rd_addr),
                                $sformatf("%h", line_addr));
            if (n_writes != exp_wb)
                report_mismatch("pmem_write count", $sformatf("%0d", n_writes),
                                $sformatf("%0d", exp_wb));
            if (exp_wb == 1 && n_writes == 1)
            begin
                if (wr_addr != exp_wb_addr)
                    report_mismatch("pmem_address", $sformatf("%h", wr_addr),
                                    $sformatf("%h", exp_wb_addr));
                if (wr_data != exp_wb_data)
                    report_mismatch("pmem_wdata", $sformatf("%h", wr_data),
                                    $sformatf("%h", exp_wb_data));
                if (!wb_first)
                begin
                    errors++;
                    $display("write-back at %0t did not come before the fill read", $time);
                end
            end
        end

        if (write_count != total_wb)
            report_mismatch("memory write count", $sformatf("%0d", write_count),
                            $sformatf("%0d", total_wb));
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+hw
hw/cache_pkg.sv
hw/cache_way.sv
hw/cache_datapath.sv
hw/cache_control.sv
hw/cache.sv
tb/pmem_model.sv
tb/cache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module cache_tb -f filelist.f -o cache_sim
./obj_dir/cache_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0
